/* list.f */
src/color_matrix_pkg.sv
src/color_matrix_regs.sv
src/fixed_matrix3x4.sv
src/color_clip.sv
src/color_matrix_core.sv
src/color_matrix_top.sv
bench/tb_color_matrix.sv

/* run.sh */
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing -Wno-fatal --timescale 1ns/1ps \
	-f list.f --top-module tb_color_matrix -o tb_color_matrix \
	&& ./obj_dir/tb_color_matrix > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "^All checks passed$" sim.log 2>/dev/null \
	&& echo "simulation PASS" \
	|| { echo "simulation FAIL"; exit 1; }

/* bench/tb_color_matrix.sv */
// 10-bit channels with 9.8 coefficients; the register map is only rewritten while no pixel is in flight
`timescale 1ns/1ps
`default_nettype none

module tb_color_matrix
	import color_matrix_pkg::*;
	();

	localparam int data_width       = 10;
	localparam int coeff_int_width  = 9;
	localparam int coeff_frac_width = 8;
	localparam int coeff_width      = coeff_int_width + coeff_frac_width;
	localparam int n_regs           = 18;

	localparam int n_pix_identity = 64;
	localparam int n_pix_matrix   = 200;
	localparam int n_clip_rounds  = 3;
	localparam int n_pix_clip     = 150;
	localparam int n_pix_cke      = 300;
	localparam int n_bus          = 4 * n_regs + 24 + 30 + 6 * n_clip_rounds;
	localparam int n_planned      = n_pix_identity + 2 * n_pix_matrix + n_clip_rounds * n_pix_clip
	                                + n_pix_cke + n_bus;
	localparam int watchdog_ns    = 20 * n_planned * 10;

	typedef struct packed {
		logic [data_width-1:0] c0;
		logic [data_width-1:0] c1;
		logic [data_width-1:0] c2;
		img_flags_t            flags;
		logic [31:0]           due;
	} expect_t;

	logic clk;
	logic reset;
	logic cke;

	axil_aw_t s_aw;
	logic     s_awvalid;
	logic     s_awready;
	axil_w_t  s_w;
	logic     s_wvalid;
	logic     s_wready;
	axil_b_t  s_b;
	logic     s_bvalid;
	logic     s_bready;
	axil_ar_t s_ar;
	logic     s_arvalid;
	logic     s_arready;
	axil_r_t  s_r;
	logic     s_rvalid;
	logic     s_rready;

	img_flags_t            s_flags;
	logic [data_width-1:0] s_color0;
	logic [data_width-1:0] s_color1;
	logic [data_width-1:0] s_color2;
	logic                  s_valid;
	img_flags_t            m_flags;
	logic [data_width-1:0] m_color0;
	logic [data_width-1:0] m_color1;
	logic [data_width-1:0] m_color2;
	logic                  m_valid;

	logic [coeff_width-1:0] model_coeff [12];
	logic [data_width-1:0]  model_min [3];
	logic [data_width-1:0]  model_max [3];
	expect_t                exp_q [$];
	logic [31:0]            lfsr_state = 32'hb407_f06a;
	logic [31:0]            cke_edges;
	logic                   last_cke;
	expect_t                prev_out;
	logic                   prev_valid;

	color_matrix_top #(
		.DATA_WIDTH       (data_width),
		.COEFF_INT_WIDTH  (coeff_int_width),
		.COEFF_FRAC_WIDTH (coeff_frac_width)
	) UUT (
		.clk       (clk),
		.reset     (reset),
		.cke       (cke),
		.s_aw      (s_aw),
		.s_awvalid (s_awvalid),
		.s_awready (s_awready),
		.s_w       (s_w),
		.s_wvalid  (s_wvalid),
		.s_wready  (s_wready),
		.s_b       (s_b),
		.s_bvalid  (s_bvalid),
		.s_bready  (s_bready),
		.s_ar      (s_ar),
		.s_arvalid (s_arvalid),
		.s_arready (s_arready),
		.s_r       (s_r),
		.s_rvalid  (s_rvalid),
		.s_rready  (s_rready),
		.s_flags   (s_flags),
		.s_color0  (s_color0),
		.s_color1  (s_color1),
		.s_color2  (s_color2),
		.s_valid   (s_valid),
		.m_flags   (m_flags),
		.m_color0  (m_color0),
		.m_color1  (m_color1),
		.m_color2  (m_color2),
		.m_valid   (m_valid)
	);

	// --------------------------------------------------
	// failure reporting and compares
	// --------------------------------------------------
	task automatic stop_on_failure();
		$display("Checks failed");
		$fatal(1);
	endtask

	task automatic abort_run(input string reason);
		$display("%s", reason);
		stop_on_failure();
	endtask

	task automatic report_mismatch(input string signal, input string expected, input string actual);
		$display("[ERROR] t=%0t %s expected %s actual %s", $time, signal, expected, actual);
		stop_on_failure();
	endtask

	task automatic check_color(input string name, input logic [data_width-1:0] expected,
		input logic [data_width-1:0] actual);
		if (actual !== expected) begin
			report_mismatch(name, $sformatf("%0d", expected), $sformatf("%0d", actual));
		end
	endtask

	task automatic check_flags(input string name, input img_flags_t expected, input img_flags_t actual);
		if (actual !== expected) begin
			report_mismatch(name, $sformatf("%b", expected), $sformatf("%b", actual));
		end
	endtask

	task automatic check_valid(input string name, input logic expected, input logic actual);
		if (actual !== expected) begin
			report_mismatch(name, $sformatf("%b", expected), $sformatf("%b", actual));
		end
	endtask

	task automatic check_pixel(input string name, input expect_t expected,
		input logic [data_width-1:0] a0, input logic [data_width-1:0] a1,
		input logic [data_width-1:0] a2, input img_flags_t af);
		check_color({name, " m_color0"}, expected.c0, a0);
		check_color({name, " m_color1"}, expected.c1, a1);
		check_color({name, " m_color2"}, expected.c2, a2);
		check_flags({name, " m_flags"}, expected.flags, af);
	endtask

	task automatic check_resp(input string name, input axil_r_t expected, input axil_r_t actual);
		if (actual !== expected) begin
			report_mismatch(name, $sformatf("data=%h resp=%0d", expected.data, expected.resp),
				$sformatf("data=%h resp=%0d", actual.data, actual.resp));
		end
	endtask

	task automatic check_bresp(input string name, input axil_b_t expected, input axil_b_t actual);
		if (actual !== expected) begin
			report_mismatch(name, $sformatf("resp=%0d", expected.resp),
				$sformatf("resp=%0d", actual.resp));
		end
	endtask

	// --------------------------------------------------
	// random source and reference model
	// --------------------------------------------------
	function automatic logic [31:0] lfsr_bits(input int n);
		logic [31:0] value;
		value = '0;
		for (int i = 0; i < n; i++) begin
			value = {value[30:0], lfsr_state[0]};
			lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'h8020_0003) : (lfsr_state >> 1);
		end
		return value;
	endfunction

	// nbits random bits, sign-extended to a full bus word
	function automatic logic [31:0] random_coeff(input int nbits);
		logic [31:0] raw;
		raw = lfsr_bits(nbits);
		if (raw[nbits-1]) begin
			raw = raw | (32'hffff_ffff << nbits);
		end
		return raw;
	endfunction

	function automatic void model_reset();
		for (int i = 0; i < 12; i++) begin
			model_coeff[i] = '0;
		end
		for (int r = 0; r < 3; r++) begin
			model_coeff[5 * r] = coeff_width'(1) << coeff_frac_width;
			model_min[r] = '0;
			model_max[r] = '1;
		end
	endfunction

	function automatic void model_write(input int word, input logic [31:0] data);
		if (word < 12) begin
			model_coeff[word] = data[coeff_width-1:0];
		end else if ((word - 12) % 2 == 0) begin
			model_min[(word - 12) / 2] = data[data_width-1:0];
		end else begin
			model_max[(word - 12) / 2] = data[data_width-1:0];
		end
	endfunction

	function automatic logic [7:0] reg_addr(input int word);
		if (word < 12) begin
			return reg_coeff_base + 8'(4 * word);
		end
		return reg_clip_base + 8'(4 * (word - 12));
	endfunction

	function automatic logic [31:0] model_reg(input int word);
		if (word < 12) begin
			return {{(32 - coeff_width){model_coeff[word][coeff_width-1]}}, model_coeff[word]};
		end else if ((word - 12) % 2 == 0) begin
			return 32'(model_min[(word - 12) / 2]);
		end
		return 32'(model_max[(word - 12) / 2]);
	endfunction

	function automatic logic [data_width-1:0] model_channel(input int row,
		input logic [data_width-1:0] c0, input logic [data_width-1:0] c1,
		input logic [data_width-1:0] c2);
		longint acc;
		acc = longint'($signed(model_coeff[4 * row])) * longint'(c0)
		      + longint'($signed(model_coeff[4 * row + 1])) * longint'(c1)
		      + longint'($signed(model_coeff[4 * row + 2])) * longint'(c2)
		      + longint'($signed(model_coeff[4 * row + 3]));
		// round half up, floor shift
		acc = (acc + (longint'(1) << (coeff_frac_width - 1))) >>> coeff_frac_width;
		if (acc > (longint'(1) << (data_width + 1)) - 1) begin
			acc = (longint'(1) << (data_width + 1)) - 1;
		end else if (acc < -(longint'(1) << (data_width + 1))) begin
			acc = -(longint'(1) << (data_width + 1));
		end
		if (acc < longint'(model_min[row])) begin
			acc = longint'(model_min[row]);
		end
		// max applied last, wins when min is above max
		if (acc > longint'(model_max[row])) begin
			acc = longint'(model_max[row]);
		end
		return acc[data_width-1:0];
	endfunction

	// --------------------------------------------------
	// bus and pixel drivers
	// --------------------------------------------------
	task automatic bus_write(input logic [7:0] addr, input logic [31:0] data,
		input logic [3:0] strb, output axil_b_t resp);
		@(posedge clk);
		#1;
		s_aw = '{addr: addr, prot: 3'd0};
		s_w = '{data: data, strb: strb};
		s_awvalid = 1'b1;
		s_wvalid = 1'b1;
		@(negedge clk);
		while (!(s_awready && s_wready)) begin
			@(negedge clk);
		end
		@(posedge clk);
		#1;
		s_awvalid = 1'b0;
		s_wvalid = 1'b0;
		s_bready = 1'b1;
		// ready lasts one cycle and the response follows on the next
		@(negedge clk);
		check_valid("s_awready", 1'b0, s_awready);
		check_valid("s_wready", 1'b0, s_wready);
		check_valid("s_bvalid", 1'b1, s_bvalid);
		resp = s_b;
		@(posedge clk);
		#1;
		s_bready = 1'b0;
		check_valid("s_bvalid", 1'b0, s_bvalid);
	endtask

	task automatic bus_read(input logic [7:0] addr, output axil_r_t resp);
		@(posedge clk);
		#1;
		s_ar = '{addr: addr};
		s_arvalid = 1'b1;
		@(negedge clk);
		while (!s_arready) begin
			@(negedge clk);
		end
		@(posedge clk);
		#1;
		s_arvalid = 1'b0;
		s_rready = 1'b1;
		@(negedge clk);
		check_valid("s_arready", 1'b0, s_arready);
		check_valid("s_rvalid", 1'b1, s_rvalid);
		resp = s_r;
		@(posedge clk);
		#1;
		s_rready = 1'b0;
		check_valid("s_rvalid", 1'b0, s_rvalid);
	endtask

	task automatic reg_write(input int word, input logic [31:0] data);
		axil_b_t b;
		bus_write(reg_addr(word), data, 4'hf, b);
		check_bresp($sformatf("s_b at 0x%02h", reg_addr(word)), '{resp: resp_okay}, b);
		model_write(word, data);
	endtask

	task automatic check_all_regs();
		axil_r_t r;
		for (int w = 0; w < n_regs; w++) begin
			bus_read(reg_addr(w), r);
			check_resp($sformatf("s_r at 0x%02h", reg_addr(w)),
				'{data: model_reg(w), resp: resp_okay}, r);
		end
	endtask

	task automatic send_pixels(input int count, input logic random_cke);
		expect_t e;
		logic [4:0] flag_bits;
		for (int i = 0; i < count; i++) begin
			@(posedge clk);
			#1;
			cke = random_cke ? (lfsr_bits(1) != 0) : 1'b1;
			s_valid = lfsr_bits(2) != 0;
			s_color0 = data_width'(lfsr_bits(data_width));
			s_color1 = data_width'(lfsr_bits(data_width));
			s_color2 = data_width'(lfsr_bits(data_width));
			flag_bits = 5'(lfsr_bits(5));
			s_flags = flag_bits;
			// only a pixel seen with cke high enters the pipeline
			if (cke && s_valid) begin
				e.c0 = model_channel(0, s_color0, s_color1, s_color2);
				e.c1 = model_channel(1, s_color0, s_color1, s_color2);
				e.c2 = model_channel(2, s_color0, s_color1, s_color2);
				e.flags = s_flags;
				e.due = cke_edges + 4;
				exp_q.push_back(e);
			end
		end
		@(posedge clk);
		#1;
		s_valid = 1'b0;
		cke = 1'b1;
	endtask

	task automatic drain_pipeline();
		while (exp_q.size() != 0) begin
			@(posedge clk);
		end
		repeat (2) @(posedge clk);
		#1;
	endtask

	// --------------------------------------------------
	// clock, edge count and output monitor
	// --------------------------------------------------
	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	always @(posedge clk) begin
		last_cke <= cke;
		if (reset) begin
			cke_edges <= '0;
		end else if (cke) begin
			cke_edges <= cke_edges + 1;
		end
	end

	always @(negedge clk) begin
		expect_t e;
		if (!reset) begin
			if (!last_cke) begin
				// stalled edge, outputs must not move
				check_valid("m_valid held", prev_valid, m_valid);
				check_pixel("held", prev_out, m_color0, m_color1, m_color2, m_flags);
			end else if (m_valid) begin
				if (exp_q.size() == 0) begin
					abort_run("an output pixel appeared while none was expected");
				end else begin
					e = exp_q.pop_front();
					if (e.due != cke_edges) begin
						abort_run($sformatf("pixel came out at cke edge %0d, expected at edge %0d",
							cke_edges, e.due));
					end else begin
						check_pixel("pixel", e, m_color0, m_color1, m_color2, m_flags);
					end
				end
			end else begin
				check_flags("idle m_flags", '0, m_flags);
				if (exp_q.size() != 0 && exp_q[0].due <= cke_edges) begin
					abort_run("an expected pixel did not come out on time");
				end
			end
		end
		prev_out.c0 = m_color0;
		prev_out.c1 = m_color1;
		prev_out.c2 = m_color2;
		prev_out.flags = m_flags;
		prev_valid = m_valid;
	end

	initial begin
		#(watchdog_ns);
		abort_run("watchdog expired before the test sequence finished");
	end

	// --------------------------------------------------
	// test sequence
	// --------------------------------------------------
	initial begin
		axil_b_t b;
		axil_r_t r;
		int word;
		logic [3:0] strb;
		reset = 1'b1;
		cke = 1'b1;
		s_aw = '0;
		s_awvalid = 1'b0;
		s_w = '0;
		s_wvalid = 1'b0;
		s_bready = 1'b0;
		s_ar = '0;
		s_arvalid = 1'b0;
		s_rready = 1'b0;
		s_flags = '0;
		s_color0 = '0;
		s_color1 = '0;
		s_color2 = '0;
		s_valid = 1'b0;
		model_reset();
		repeat (3) @(posedge clk);
		#1;
		reset = 1'b0;

		check_all_regs();
		// identity matrix, pixels pass unchanged
		send_pixels(n_pix_identity, 1'b0);
		drain_pipeline();

		// unmapped words and partial strobes
		for (int i = 0; i < 8; i++) begin
			word = n_regs + int'(lfsr_bits(6)) % (64 - n_regs);
			bus_read(8'(4 * word), r);
			check_resp("s_r unmapped", '{data: 32'd0, resp: resp_slverr}, r);
			bus_write(8'(4 * word), lfsr_bits(32), 4'hf, b);
			check_bresp("s_b unmapped", '{resp: resp_slverr}, b);
			strb = 4'(lfsr_bits(4));
			if (strb == 4'hf) begin
				strb = 4'h7;
			end
			bus_write(reg_addr(int'(lfsr_bits(5)) % n_regs), lfsr_bits(32), strb, b);
			check_bresp("s_b partial strobe", '{resp: resp_slverr}, b);
		end
		check_all_regs();

		// full random words, only the low bits are kept
		for (int w = 0; w < n_regs; w++) begin
			reg_write(w, lfsr_bits(32));
		end
		check_all_regs();

		for (int k = 0; k < 3; k++) begin
			reg_write(12 + 2 * k, 32'd0);
			reg_write(13 + 2 * k, 32'((1 << data_width) - 1));
		end
		// full-range coefficients drive most sums into saturation
		for (int w = 0; w < 12; w++) begin
			reg_write(w, random_coeff(coeff_width));
		end
		send_pixels(n_pix_matrix, 1'b0);
		drain_pipeline();

		for (int w = 0; w < 12; w++) begin
			reg_write(w, (w % 4 == 3) ? random_coeff(coeff_width) : random_coeff(coeff_frac_width + 1));
		end
		send_pixels(n_pix_matrix, 1'b0);
		drain_pipeline();

		// random limits, min above max included
		for (int round = 0; round < n_clip_rounds; round++) begin
			for (int k = 0; k < 6; k++) begin
				reg_write(12 + k, lfsr_bits(data_width));
			end
			send_pixels(n_pix_clip, 1'b0);
			drain_pipeline();
		end

		send_pixels(n_pix_cke, 1'b1);
		drain_pipeline();

		if (exp_q.size() == 0) begin
			$display("All checks passed");
			$finish;
		end else begin
			abort_run("pixels were still expected at the end of the run");
		end
	end

endmodule

`default_nettype wire

/* src/color_matrix_top.sv */
// no pixel back-pressure, cke stalls the pixel path only; the bus runs regardless of cke
`timescale 1ns/1ps
`default_nettype none

module color_matrix_top
	import color_matrix_pkg::*;
	#(
		parameter int DATA_WIDTH       = 10,
		parameter int COEFF_INT_WIDTH  = 9,
		parameter int COEFF_FRAC_WIDTH = 8
	)
	(
		input  logic clk,
		input  logic reset,
		input  logic cke,

		input  axil_aw_t s_aw,
		input  logic     s_awvalid,
		output logic     s_awready,
		input  axil_w_t  s_w,
		input  logic     s_wvalid,
		output logic     s_wready,
		output axil_b_t  s_b,
		output logic     s_bvalid,
		input  logic     s_bready,
		input  axil_ar_t s_ar,
		input  logic     s_arvalid,
		output logic     s_arready,
		output axil_r_t  s_r,
		output logic     s_rvalid,
		input  logic     s_rready,

		input  img_flags_t             s_flags,
		input  logic [DATA_WIDTH-1:0]  s_color0,
		input  logic [DATA_WIDTH-1:0]  s_color1,
		input  logic [DATA_WIDTH-1:0]  s_color2,
		input  logic                   s_valid,

		output img_flags_t             m_flags,
		output logic [DATA_WIDTH-1:0]  m_color0,
		output logic [DATA_WIDTH-1:0]  m_color1,
		output logic [DATA_WIDTH-1:0]  m_color2,
		output logic                   m_valid
	);

	logic [11:0][COEFF_INT_WIDTH+COEFF_FRAC_WIDTH-1:0] coeff;
	logic [2:0][DATA_WIDTH-1:0]                        clip_min;
	logic [2:0][DATA_WIDTH-1:0]                        clip_max;

	color_matrix_regs #(
		.DATA_WIDTH       (DATA_WIDTH),
		.COEFF_INT_WIDTH  (COEFF_INT_WIDTH),
		.COEFF_FRAC_WIDTH (COEFF_FRAC_WIDTH)
	) u_regs (
		.clk       (clk),
		.reset     (reset),
		.s_aw      (s_aw),
		.s_awvalid (s_awvalid),
		.s_awready (s_awready),
		.s_w       (s_w),
		.s_wvalid  (s_wvalid),
		.s_wready  (s_wready),
		.s_b       (s_b),
		.s_bvalid  (s_bvalid),
		.s_bready  (s_bready),
		.s_ar      (s_ar),
		.s_arvalid (s_arvalid),
		.s_arready (s_arready),
		.s_r       (s_r),
		.s_rvalid  (s_rvalid),
		.s_rready  (s_rready),
		.coeff     (coeff),
		.clip_min  (clip_min),
		.clip_max  (clip_max)
	);

	color_matrix_core #(
		.DATA_WIDTH       (DATA_WIDTH),
		.COEFF_INT_WIDTH  (COEFF_INT_WIDTH),
		.COEFF_FRAC_WIDTH (COEFF_FRAC_WIDTH)
	) u_core (
		.clk      (clk),
		.reset    (reset),
		.cke      (cke),
		.coeff    (coeff),
		.clip_min (clip_min),
		.clip_max (clip_max),
		.s_flags  (s_flags),
		.s_color0 (s_color0),
		.s_color1 (s_color1),
		.s_color2 (s_color2),
		.s_valid  (s_valid),
		.m_flags  (m_flags),
		.m_color0 (m_color0),
		.m_color1 (m_color1),
		.m_color2 (m_color2),
		.m_valid  (m_valid)
	);

endmodule

`default_nettype wire

/* src/color_matrix_core.sv */
// pixel path of 4 cke-high cycles; coefficients and limits may change at any time
`timescale 1ns/1ps
`default_nettype none

module color_matrix_core
	import color_matrix_pkg::*;
	#(
		parameter int DATA_WIDTH       = 10,
		parameter int COEFF_INT_WIDTH  = 9,
		parameter int COEFF_FRAC_WIDTH = 8
	)
	(
		input  logic clk,
		input  logic reset,
		input  logic cke,

		input  logic [11:0][COEFF_INT_WIDTH+COEFF_FRAC_WIDTH-1:0] coeff,
		input  logic [2:0][DATA_WIDTH-1:0]                        clip_min,
		input  logic [2:0][DATA_WIDTH-1:0]                        clip_max,

		input  img_flags_t             s_flags,
		input  logic [DATA_WIDTH-1:0]  s_color0,
		input  logic [DATA_WIDTH-1:0]  s_color1,
		input  logic [DATA_WIDTH-1:0]  s_color2,
		input  logic                   s_valid,

		output img_flags_t             m_flags,
		output logic [DATA_WIDTH-1:0]  m_color0,
		output logic [DATA_WIDTH-1:0]  m_color1,
		output logic [DATA_WIDTH-1:0]  m_color2,
		output logic                   m_valid
	);

	// matrix result, two bits wider and signed
	img_flags_t                   mat_flags;
	logic signed [DATA_WIDTH+1:0] mat_color0;
	logic signed [DATA_WIDTH+1:0] mat_color1;
	logic signed [DATA_WIDTH+1:0] mat_color2;
	logic                         mat_valid;

	fixed_matrix3x4 #(
		.DATA_WIDTH       (DATA_WIDTH),
		.COEFF_INT_WIDTH  (COEFF_INT_WIDTH),
		.COEFF_FRAC_WIDTH (COEFF_FRAC_WIDTH)
	) u_matrix (
		.clk      (clk),
		.reset    (reset),
		.cke      (cke),
		.coeff    (coeff),
		.s_flags  (s_flags),
		.s_color0 (s_color0),
		.s_color1 (s_color1),
		.s_color2 (s_color2),
		.s_valid  (s_valid),
		.m_flags  (mat_flags),
		.m_color0 (mat_color0),
		.m_color1 (mat_color1),
		.m_color2 (mat_color2),
		.m_valid  (mat_valid)
	);

	color_clip #(
		.DATA_WIDTH (DATA_WIDTH)
	) u_clip (
		.clk      (clk),
		.reset    (reset),
		.cke      (cke),
		.clip_min (clip_min),
		.clip_max (clip_max),
		.s_flags  (mat_flags),
		.s_color0 (mat_color0),
		.s_color1 (mat_color1),
		.s_color2 (mat_color2),
		.s_valid  (mat_valid),
		.m_flags  (m_flags),
		.m_color0 (m_color0),
		.m_color1 (m_color1),
		.m_color2 (m_color2),
		.m_valid  (m_valid)
	);

endmodule

`default_nettype wire

/* src/color_clip.sv */
// limits are unsigned DATA_WIDTH values; with min above max every output is the max limit
`timescale 1ns/1ps
`default_nettype none

module color_clip
	import color_matrix_pkg::*;
	#(
		parameter int DATA_WIDTH = 10
	)
	(
		input  logic clk,
		input  logic reset,
		input  logic cke,

		input  logic [2:0][DATA_WIDTH-1:0] clip_min,
		input  logic [2:0][DATA_WIDTH-1:0] clip_max,

		input  img_flags_t                   s_flags,
		input  logic signed [DATA_WIDTH+1:0] s_color0,
		input  logic signed [DATA_WIDTH+1:0] s_color1,
		input  logic signed [DATA_WIDTH+1:0] s_color2,
		input  logic                         s_valid,

		output img_flags_t                   m_flags,
		output logic        [DATA_WIDTH-1:0] m_color0,
		output logic        [DATA_WIDTH-1:0] m_color1,
		output logic        [DATA_WIDTH-1:0] m_color2,
		output logic                         m_valid
	);

	logic signed [DATA_WIDTH+1:0] in_color [3];
	logic [DATA_WIDTH-1:0]        clip_color [3];
	logic [DATA_WIDTH-1:0]        color_q [3];
	img_flags_t                   flags_q;
	logic                         valid_q;

	assign in_color[0] = s_color0;
	assign in_color[1] = s_color1;
	assign in_color[2] = s_color2;

	always_comb begin
		for (int ch = 0; ch < 3; ch++) begin
			clip_color[ch] = in_color[ch][DATA_WIDTH-1:0];
			if (in_color[ch] < $signed({2'b00, clip_min[ch]})) begin
				clip_color[ch] = clip_min[ch];
			end
			// max checked last so it overrides
			if (in_color[ch] > $signed({2'b00, clip_max[ch]})
			    || clip_min[ch] > clip_max[ch]) begin
				clip_color[ch] = clip_max[ch];
			end
		end
	end

	always_ff @(posedge clk) begin
		if (cke) begin
			color_q <= clip_color;
			flags_q <= s_valid ? s_flags : '0;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			valid_q <= 1'b0;
		end else if (cke) begin
			valid_q <= s_valid;
		end
	end

	assign m_flags  = flags_q;
	assign m_color0 = color_q[0];
	assign m_color1 = color_q[1];
	assign m_color2 = color_q[2];
	assign m_valid  = valid_q;

endmodule

`default_nettype wire

/* src/fixed_matrix3x4.sv */
// colors are unsigned integers, COEFF_FRAC_WIDTH must be 1 or more, latency is 3 cke-high cycles
`timescale 1ns/1ps
`default_nettype none

module fixed_matrix3x4
	import color_matrix_pkg::*;
	#(
		parameter int DATA_WIDTH       = 10,
		parameter int COEFF_INT_WIDTH  = 9,
		parameter int COEFF_FRAC_WIDTH = 8
	)
	(
		input  logic clk,
		input  logic reset,
		input  logic cke,

		input  logic [11:0][COEFF_INT_WIDTH+COEFF_FRAC_WIDTH-1:0] coeff,

		input  img_flags_t                    s_flags,
		input  logic        [DATA_WIDTH-1:0]  s_color0,
		input  logic        [DATA_WIDTH-1:0]  s_color1,
		input  logic        [DATA_WIDTH-1:0]  s_color2,
		input  logic                          s_valid,

		output img_flags_t                    m_flags,
		output logic signed [DATA_WIDTH+1:0]  m_color0,
		output logic signed [DATA_WIDTH+1:0]  m_color1,
		output logic signed [DATA_WIDTH+1:0]  m_color2,
		output logic                          m_valid
	);

	localparam int coeff_width = COEFF_INT_WIDTH + COEFF_FRAC_WIDTH;
	localparam int prod_width  = coeff_width + DATA_WIDTH + 1;
	// three products plus the offset
	localparam int sum_width   = prod_width + 2;
	localparam int rnd_width   = sum_width + 1;
	localparam int out_width   = DATA_WIDTH + 2;

	localparam logic signed [rnd_width-1:0] round_half = rnd_width'(1) << (COEFF_FRAC_WIDTH - 1);
	localparam logic signed [out_width-1:0] sat_max    = {1'b0, {(out_width-1){1'b1}}};
	localparam logic signed [out_width-1:0] sat_min    = {1'b1, {(out_width-1){1'b0}}};

	logic signed [DATA_WIDTH:0]  color_s [3];
	logic signed [prod_width-1:0] prod_q [3][3];
	logic signed [sum_width-1:0]  sum_q [3];
	logic signed [rnd_width-1:0]  rnd [3];
	logic signed [rnd_width-1:0]  shf [3];
	logic signed [out_width-1:0]  sat [3];
	logic signed [out_width-1:0]  color_q [3];
	img_flags_t                   flags_q [3];
	logic [2:0]                   valid_q;

	assign color_s[0] = $signed({1'b0, s_color0});
	assign color_s[1] = $signed({1'b0, s_color1});
	assign color_s[2] = $signed({1'b0, s_color2});

	// round half up, then back to integer
	always_comb begin
		for (int r = 0; r < 3; r++) begin
			rnd[r] = sum_q[r] + round_half;
			shf[r] = rnd[r] >>> COEFF_FRAC_WIDTH;
			if (shf[r] > sat_max) begin
				sat[r] = sat_max;
			end else if (shf[r] < sat_min) begin
				sat[r] = sat_min;
			end else begin
				sat[r] = shf[r][out_width-1:0];
			end
		end
	end

	always_ff @(posedge clk) begin
		if (cke) begin
			for (int r = 0; r < 3; r++) begin
				for (int c = 0; c < 3; c++) begin
					prod_q[r][c] <= $signed(coeff[4*r+c]) * color_s[c];
				end
				sum_q[r]   <= prod_q[r][0] + prod_q[r][1] + prod_q[r][2]
				              + $signed(coeff[4*r+3]);
				color_q[r] <= sat[r];
			end
			flags_q[0] <= s_flags;
			flags_q[1] <= flags_q[0];
			flags_q[2] <= flags_q[1];
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			valid_q <= '0;
		end else if (cke) begin
			valid_q <= {valid_q[1:0], s_valid};
		end
	end

	assign m_flags  = flags_q[2];
	assign m_color0 = color_q[0];
	assign m_color1 = color_q[1];
	assign m_color2 = color_q[2];
	assign m_valid  = valid_q[2];

endmodule

`default_nettype wire

/* src/color_matrix_regs.sv */
// writes apply at once with no shadowing; address bits [1:0] are ignored and partial strobes are refused
`timescale 1ns/1ps
`default_nettype none

module color_matrix_regs
	import color_matrix_pkg::*;
	#(
		parameter int DATA_WIDTH       = 10,
		parameter int COEFF_INT_WIDTH  = 9,
		parameter int COEFF_FRAC_WIDTH = 8
	)
	(
		input  logic clk,
		input  logic reset,

		input  axil_aw_t s_aw,
		input  logic     s_awvalid,
		output logic     s_awready,
		input  axil_w_t  s_w,
		input  logic     s_wvalid,
		output logic     s_wready,
		output axil_b_t  s_b,
		output logic     s_bvalid,
		input  logic     s_bready,
		input  axil_ar_t s_ar,
		input  logic     s_arvalid,
		output logic     s_arready,
		output axil_r_t  s_r,
		output logic     s_rvalid,
		input  logic     s_rready,

		output logic [11:0][COEFF_INT_WIDTH+COEFF_FRAC_WIDTH-1:0] coeff,
		output logic [2:0][DATA_WIDTH-1:0]                        clip_min,
		output logic [2:0][DATA_WIDTH-1:0]                        clip_max
	);

	localparam int coeff_width = COEFF_INT_WIDTH + COEFF_FRAC_WIDTH;
	localparam logic [coeff_width-1:0] coeff_one = coeff_width'(1) << COEFF_FRAC_WIDTH;
	localparam logic [5:0] coeff_word = reg_coeff_base[7:2];
	localparam logic [5:0] clip_word  = reg_clip_base[7:2];

	logic [5:0]  wr_coeff_off;
	logic [5:0]  wr_clip_off;
	logic        wr_coeff_hit;
	logic        wr_clip_hit;
	logic        wr_ok;
	logic        wr_fire;
	logic [5:0]  rd_coeff_off;
	logic [5:0]  rd_clip_off;
	logic        rd_fire;
	logic [31:0] rd_data;
	logic [1:0]  rd_resp;

	// --------------------------------------------------
	// address decode
	// --------------------------------------------------
	assign wr_coeff_off = s_aw.addr[7:2] - coeff_word;
	assign wr_clip_off  = s_aw.addr[7:2] - clip_word;
	assign wr_coeff_hit = wr_coeff_off < 6'd12;
	assign wr_clip_hit  = wr_clip_off < 6'd6;
	assign wr_ok        = (wr_coeff_hit || wr_clip_hit) && (&s_w.strb);
	assign wr_fire      = s_awready && s_awvalid && s_wready && s_wvalid;

	assign rd_coeff_off = s_ar.addr[7:2] - coeff_word;
	assign rd_clip_off  = s_ar.addr[7:2] - clip_word;
	assign rd_fire      = s_arready && s_arvalid;

	always_comb begin
		rd_data = '0;
		rd_resp = resp_slverr;
		if (rd_coeff_off < 6'd12) begin
			// coefficients read back sign-extended
			rd_data = 32'($signed(coeff[rd_coeff_off[3:0]]));
			rd_resp = resp_okay;
		end else if (rd_clip_off < 6'd6) begin
			rd_data = rd_clip_off[0] ? 32'(clip_max[rd_clip_off[2:1]])
			                         : 32'(clip_min[rd_clip_off[2:1]]);
			rd_resp = resp_okay;
		end
	end

	// --------------------------------------------------
	// handshakes
	// --------------------------------------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			s_awready <= 1'b0;
			s_wready  <= 1'b0;
			s_bvalid  <= 1'b0;
			s_arready <= 1'b0;
			s_rvalid  <= 1'b0;
		end else begin
			// one-cycle ready pulses, none while a response is pending
			s_awready <= s_awvalid && s_wvalid && !s_awready && !s_bvalid;
			s_wready  <= s_awvalid && s_wvalid && !s_awready && !s_bvalid;
			s_arready <= s_arvalid && !s_arready && !s_rvalid;
			if (wr_fire) begin
				s_bvalid <= 1'b1;
			end else if (s_bready) begin
				s_bvalid <= 1'b0;
			end
			if (rd_fire) begin
				s_rvalid <= 1'b1;
			end else if (s_rready) begin
				s_rvalid <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (wr_fire) begin
			s_b.resp <= wr_ok ? resp_okay : resp_slverr;
		end
		if (rd_fire) begin
			s_r <= '{data: rd_data, resp: rd_resp};
		end
	end

	// --------------------------------------------------
	// coefficient bank and clip limits
	// --------------------------------------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < 12; i++) begin
				coeff[i] <= '0;
			end
			for (int r = 0; r < 3; r++) begin
				coeff[5*r]  <= coeff_one;
				clip_min[r] <= '0;
				clip_max[r] <= '1;
			end
		end else if (wr_fire && wr_ok) begin
			if (wr_coeff_hit) begin
				coeff[wr_coeff_off[3:0]] <= s_w.data[coeff_width-1:0];
			end else if (wr_clip_off[0]) begin
				clip_max[wr_clip_off[2:1]] <= s_w.data[DATA_WIDTH-1:0];
			end else begin
				clip_min[wr_clip_off[2:1]] <= s_w.data[DATA_WIDTH-1:0];
			end
		end
	end

endmodule

`default_nettype wire

/* src/color_matrix_pkg.sv */
// bus addresses are 8-bit byte addresses over 32-bit words; coefficient and clip widths are set per module
`default_nettype none

package color_matrix_pkg;

	// --------------------------------------------------
	// pixel side-band
	// --------------------------------------------------
	typedef struct packed {
		logic line_first;
		logic line_last;
		logic pixel_first;
		logic pixel_last;
		logic de;
	} img_flags_t;

	// --------------------------------------------------
	// AXI4-Lite channels
	// --------------------------------------------------
	typedef struct packed {
		logic [7:0] addr;
		logic [2:0] prot;
	} axil_aw_t;

	// a register only takes a write with all four strobes set
	typedef struct packed {
		logic [31:0] data;
		logic [3:0]  strb;
	} axil_w_t;

	typedef struct packed {
		logic [1:0] resp;
	} axil_b_t;

	typedef struct packed {
		logic [7:0] addr;
	} axil_ar_t;

	typedef struct packed {
		logic [31:0] data;
		logic [1:0]  resp;
	} axil_r_t;

	localparam logic [1:0] resp_okay   = 2'd0;
	localparam logic [1:0] resp_slverr = 2'd2;

	// coefficient row r, column c at word 4r+c
	localparam logic [7:0] reg_coeff_base = 8'h00;
	// min0, max0, min1, max1, min2, max2
	localparam logic [7:0] reg_clip_base  = 8'h30;

endpackage

`default_nettype wire
